// ==== rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN = 32;
    localparam int ALEN = 32;

    typedef logic [XLEN-1:0] xdata_t;
    typedef logic [ALEN-1:0] addr_t;
    typedef logic [4:0]      reg_sel_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;

    // opcode is instr[6:2] since the low two bits are always 2'b11
    localparam opcode_t OPC_OP     = 5'b01100;
    localparam opcode_t OPC_OP_IMM = 5'b00100;
    localparam opcode_t OPC_LUI    = 5'b01101;
    localparam opcode_t OPC_AUIPC  = 5'b00101;
    localparam opcode_t OPC_JAL    = 5'b11011;
    localparam opcode_t OPC_JALR   = 5'b11001;
    localparam opcode_t OPC_BRANCH = 5'b11000;

    // alternate form for SUB and SRA/SRAI
    localparam funct7_t F7_ALT = 7'b0100000;

    typedef enum logic [1:0] {
        DEC_EMPTY,
        DEC_FULL,
        DEC_HALTED
    } decode_state_t;

endpackage

// ==== decode.sv ====
`timescale 1ns/1ns

module decode import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     prev_stalled,
    input  instr_t   instr,
    input  addr_t    instr_addr,
    input  logic     exec_pipeline_flush,
    input  logic     stall_prev,
    output logic     stall_this,

    output logic     decode_stalled,
    output logic     decode_exception,
    output logic     decode_is_jump,
    output logic     decode_is_reg_write,
    output addr_t    decode_instruction_addr,
    output addr_t    decode_instruction_next_addr,
    output opcode_t  opcode,
    output reg_sel_t rd,
    output funct3_t  funct3,
    output reg_sel_t rs1,
    output reg_sel_t rs2,
    output funct7_t  funct7,
    output xdata_t   decode_rs1_data,
    output xdata_t   decode_rs2_data,
    output xdata_t   i_imm,
    output xdata_t   u_imm,
    output xdata_t   j_imm,
    output xdata_t   b_imm,

    output reg_sel_t rs1_sel,
    output reg_sel_t rs2_sel,
    input  xdata_t   rs1_rdata,
    input  xdata_t   rs2_rdata
);

    decode_state_t state;
    opcode_t       in_opcode;
    funct3_t       in_funct3;
    funct7_t       in_funct7;
    logic          in_illegal;
    logic          in_is_jump;
    logic          in_is_reg_write;
    logic          take;
    logic          pass;

    assign in_opcode = instr[6:2];
    assign in_funct3 = instr[14:12];
    assign in_funct7 = instr[31:25];
    // register file is read while the instruction is offered
    assign rs1_sel = instr[19:15];
    assign rs2_sel = instr[24:20];

    always_comb begin
        in_is_jump = 1'b0;
        in_is_reg_write = 1'b1;
        in_illegal = instr[1:0] != 2'b11;
        case (in_opcode)
            OPC_OP: begin
                // only ADD/SUB and SRL/SRA have an alternate form
                if (in_funct7 == F7_ALT)
                    in_illegal = in_illegal || (in_funct3 != 3'b000 && in_funct3 != 3'b101);
                else if (in_funct7 != 7'b0)
                    in_illegal = 1'b1;
            end
            OPC_OP_IMM, OPC_LUI, OPC_AUIPC: begin
            end
            OPC_JAL, OPC_JALR: in_is_jump = 1'b1;
            OPC_BRANCH: begin
                in_is_jump = 1'b1;
                in_is_reg_write = 1'b0;
            end
            default: begin
                in_illegal = 1'b1;
                in_is_reg_write = 1'b0;
            end
        endcase
    end

    // an offered instruction is dropped while a flush is up
    assign take = !prev_stalled && !stall_this && !exec_pipeline_flush;
    assign pass = state == DEC_FULL && !stall_prev;
    assign stall_this = (state == DEC_FULL && stall_prev) || state == DEC_HALTED;
    assign decode_stalled = state != DEC_FULL;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DEC_EMPTY;
        end else if (exec_pipeline_flush) begin
            state <= DEC_EMPTY;
        end else if (pass && decode_exception) begin
            state <= DEC_HALTED;
        end else if (take) begin
            state <= DEC_FULL;
        end else if (pass) begin
            state <= DEC_EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            decode_exception <= in_illegal;
            decode_is_jump <= in_is_jump;
            decode_is_reg_write <= in_is_reg_write;
            decode_instruction_addr <= instr_addr;
            decode_instruction_next_addr <= instr_addr + addr_t'(4);
            opcode <= in_opcode;
            rd <= instr[11:7];
            funct3 <= in_funct3;
            rs1 <= rs1_sel;
            rs2 <= rs2_sel;
            funct7 <= in_funct7;
            decode_rs1_data <= rs1_rdata;
            decode_rs2_data <= rs2_rdata;
            i_imm <= {{20{instr[31]}}, instr[31:20]};
            u_imm <= {instr[31:12], 12'b0};
            j_imm <= {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            b_imm <= {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        end
    end

endmodule

// ==== exec_int.sv ====
`timescale 1ns/1ns

module exec_int import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    input_valid,
    input  logic    input_is_int,
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  funct7_t funct7,
    input  xdata_t  i_imm,
    input  xdata_t  u_imm,
    input  addr_t   decode_instruction_addr,
    input  xdata_t  rs1_data,
    input  xdata_t  rs2_data,
    output logic    exec_int_output_valid,
    output logic    exec_int_exception,
    output xdata_t  exec_int_result
);

    xdata_t operand_b;
    xdata_t result;
    logic   alt;
    logic   illegal;
    logic   fire;

    assign operand_b = opcode == OPC_OP ? rs2_data : i_imm;
    assign alt = funct7 == F7_ALT;
    assign fire = input_valid && input_is_int;

    always_comb begin
        illegal = 1'b0;
        result = '0;
        if (opcode == OPC_LUI) begin
            result = u_imm;
        end else if (opcode == OPC_AUIPC) begin
            result = decode_instruction_addr + u_imm;
        end else begin
            case (funct3)
                3'b000: begin
                    if (opcode == OPC_OP && alt)
                        result = rs1_data - operand_b;
                    else
                        result = rs1_data + operand_b;
                end
                3'b001: result = rs1_data << operand_b[4:0];
                3'b010: result = xdata_t'($signed(rs1_data) < $signed(operand_b));
                3'b011: result = xdata_t'(rs1_data < operand_b);
                3'b100: result = rs1_data ^ operand_b;
                3'b101: begin
                    if (alt)
                        result = $signed(rs1_data) >>> operand_b[4:0];
                    else
                        result = rs1_data >> operand_b[4:0];
                end
                3'b110: result = rs1_data | operand_b;
                default: result = rs1_data & operand_b;
            endcase
            // immediate shifts carry funct7 too; decode only screens OP
            if (opcode == OPC_OP || funct3 == 3'b001 || funct3 == 3'b101)
                illegal = funct7 != 7'b0
                          && !(alt && (funct3 == 3'b101 || (funct3 == 3'b000 && opcode == OPC_OP)));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_int_output_valid <= 1'b0;
            exec_int_exception <= 1'b0;
        end else begin
            exec_int_output_valid <= fire;
            exec_int_exception <= fire && illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (fire)
            exec_int_result <= result;
    end

endmodule

// ==== exec_branch.sv ====
`timescale 1ns/1ns

module exec_branch import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    input_valid,
    input  logic    input_is_branch,
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  xdata_t  i_imm,
    input  xdata_t  j_imm,
    input  xdata_t  b_imm,
    input  addr_t   decode_instruction_addr,
    input  addr_t   decode_instruction_next_addr,
    input  xdata_t  rs1_data,
    input  xdata_t  rs2_data,
    output logic    exec_branch_output_valid,
    output logic    exec_branch_exception,
    output xdata_t  exec_branch_result,
    output addr_t   exec_branch_target,
    output logic    exec_mispredict_detected
);

    addr_t target;
    logic  taken;
    logic  bad_funct3;
    logic  fault;
    logic  fire;

    always_comb begin
        taken = 1'b0;
        bad_funct3 = 1'b0;
        target = decode_instruction_addr + b_imm;
        case (opcode)
            OPC_JAL: begin
                taken = 1'b1;
                target = decode_instruction_addr + j_imm;
            end
            OPC_JALR: begin
                taken = 1'b1;
                target = (rs1_data + i_imm) & ~addr_t'(1);
                bad_funct3 = funct3 != 3'b000;
            end
            default: begin
                case (funct3)
                    3'b000: taken = rs1_data == rs2_data;
                    3'b001: taken = rs1_data != rs2_data;
                    3'b100: taken = $signed(rs1_data) < $signed(rs2_data);
                    3'b101: taken = $signed(rs1_data) >= $signed(rs2_data);
                    3'b110: taken = rs1_data < rs2_data;
                    3'b111: taken = rs1_data >= rs2_data;
                    default: bad_funct3 = 1'b1;
                endcase
            end
        endcase
    end

    // only a taken transfer can fault on its target
    assign fault = bad_funct3 || (taken && target[1:0] != 2'b00);
    assign fire = input_valid && input_is_branch;

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_branch_output_valid <= 1'b0;
            exec_branch_exception <= 1'b0;
            exec_mispredict_detected <= 1'b0;
        end else begin
            exec_branch_output_valid <= fire;
            exec_branch_exception <= fire && fault;
            // no predictor, so every taken transfer redirects fetch
            exec_mispredict_detected <= fire && taken && !fault;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            exec_branch_result <= decode_instruction_next_addr;
            exec_branch_target <= target;
        end
    end

endmodule

// ==== exec.sv ====
`timescale 1ns/1ns

module exec import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     prev_stalled,
    output logic     stall_prev,
    output logic     stall_next,

    input  logic     decode_exception,
    input  logic     decode_is_jump,
    input  logic     decode_is_reg_write,
    input  addr_t    decode_instruction_addr,
    input  addr_t    decode_instruction_next_addr,
    input  opcode_t  opcode,
    input  reg_sel_t rd,
    input  funct3_t  funct3,
    input  reg_sel_t rs1,
    input  reg_sel_t rs2,
    input  funct7_t  funct7,
    input  xdata_t   decode_rs1_data,
    input  xdata_t   decode_rs2_data,
    input  xdata_t   i_imm,
    input  xdata_t   u_imm,
    input  xdata_t   j_imm,
    input  xdata_t   b_imm,

    output logic     exec_exception,
    output logic     exec_is_branch,
    output logic     exec_is_reg_write,
    output reg_sel_t exec_reg_write_sel,
    output xdata_t   exec_result,
    output addr_t    exec_branch_target,
    output logic     exec_pipeline_flush
);

    logic   busy;
    logic   stopped_after_exception;
    logic   accept;
    logic   input_valid;
    logic   input_is_int;
    logic   input_is_branch;
    logic   result_commit;
    xdata_t rs1_data;
    xdata_t rs2_data;

    logic   exec_int_output_valid;
    logic   exec_int_exception;
    xdata_t exec_int_result;
    logic   exec_branch_output_valid;
    logic   exec_branch_exception;
    xdata_t exec_branch_result;

    // decode read its operands a cycle before this result reached the register file
    assign result_commit = !stall_next && exec_is_reg_write && !exec_exception
                           && exec_reg_write_sel != '0;
    assign rs1_data = (result_commit && exec_reg_write_sel == rs1) ? exec_result
                                                                   : decode_rs1_data;
    assign rs2_data = (result_commit && exec_reg_write_sel == rs2) ? exec_result
                                                                   : decode_rs2_data;

    // items behind a taken transfer or an exception are dropped
    assign accept = !prev_stalled && !stall_prev && !exec_pipeline_flush && !exec_exception;
    assign input_valid = accept && !decode_exception;
    assign input_is_int = !opcode[4] && opcode[2];
    assign input_is_branch = decode_is_jump;
    assign exec_is_branch = exec_branch_output_valid;
    assign stall_prev = busy && stall_next;

    exec_int exec_int0 (.*);

    exec_branch exec_branch0 (
        .exec_mispredict_detected(exec_pipeline_flush),
        .*
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            stopped_after_exception <= 1'b0;
            exec_is_reg_write <= 1'b0;
            exec_reg_write_sel <= '0;
        end else begin
            if (input_valid) begin
                busy <= 1'b1;
                exec_is_reg_write <= decode_is_reg_write;
                exec_reg_write_sel <= rd;
            end else if (!stall_next) begin
                busy <= 1'b0;
            end
            // once stopped, hold decode off for good
            if ((accept && decode_exception) || exec_exception) begin
                stopped_after_exception <= 1'b1;
                busy <= 1'b1;
            end
        end
    end

    always_comb begin
        unique case (1'b1)
            exec_branch_output_valid: begin
                stall_next = 1'b0;
                exec_exception = exec_branch_exception;
                exec_result = exec_branch_result;
            end
            exec_int_output_valid: begin
                stall_next = 1'b0;
                exec_exception = exec_int_exception;
                exec_result = exec_int_result;
            end
            default: begin
                stall_next = 1'b1;
                exec_exception = stopped_after_exception;
                exec_result = '0;
            end
        endcase
    end

endmodule

// ==== writeback.sv ====
`timescale 1ns/1ns

module writeback import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     we,
    input  reg_sel_t waddr,
    input  xdata_t   wdata,
    input  reg_sel_t rs1_sel,
    input  reg_sel_t rs2_sel,
    output xdata_t   rs1_rdata,
    output xdata_t   rs2_rdata
);

    xdata_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write goes straight through to the readers
    assign rs1_rdata = (rs1_sel == '0) ? '0
                     : (we && waddr == rs1_sel) ? wdata
                     : regs[rs1_sel];
    assign rs2_rdata = (rs2_sel == '0) ? '0
                     : (we && waddr == rs2_sel) ? wdata
                     : regs[rs2_sel];

endmodule

// ==== core_exec_top.sv ====
`timescale 1ns/1ns

module core_exec_top import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     instr_valid,
    input  instr_t   instr,
    input  addr_t    instr_addr,
    output logic     instr_stall,
    output logic     redirect_valid,
    output addr_t    redirect_addr,
    output logic     wb_valid,
    output reg_sel_t wb_rd,
    output xdata_t   wb_data,
    output logic     exception
);

    logic     stall_prev;
    logic     stall_next;
    logic     decode_stalled;
    logic     decode_exception;
    logic     decode_is_jump;
    logic     decode_is_reg_write;
    addr_t    decode_instruction_addr;
    addr_t    decode_instruction_next_addr;
    opcode_t  opcode;
    reg_sel_t rd;
    funct3_t  funct3;
    reg_sel_t rs1;
    reg_sel_t rs2;
    funct7_t  funct7;
    xdata_t   decode_rs1_data;
    xdata_t   decode_rs2_data;
    xdata_t   i_imm;
    xdata_t   u_imm;
    xdata_t   j_imm;
    xdata_t   b_imm;
    reg_sel_t rs1_sel;
    reg_sel_t rs2_sel;
    xdata_t   rs1_rdata;
    xdata_t   rs2_rdata;
    logic     exec_is_reg_write;

    // x0 writes and anything from a faulting item never reach the register file
    assign wb_valid = !stall_next && exec_is_reg_write && !exception && wb_rd != '0;

    decode decode0 (
        .prev_stalled(!instr_valid),
        .stall_this(instr_stall),
        .exec_pipeline_flush(redirect_valid),
        .*
    );

    exec exec0 (
        .prev_stalled(decode_stalled),
        .exec_exception(exception),
        .exec_is_branch(),
        .exec_reg_write_sel(wb_rd),
        .exec_result(wb_data),
        .exec_branch_target(redirect_addr),
        .exec_pipeline_flush(redirect_valid),
        .*
    );

    writeback writeback0 (
        .we(wb_valid),
        .waddr(wb_rd),
        .wdata(wb_data),
        .*
    );

endmodule

// ==== tb_core_exec.sv ====
`timescale 1ns/1ns

module tb_core_exec import rv_pkg::*; ();

    localparam int EV_WB = 0;
    localparam int EV_REDIR = 1;
    localparam int EV_EXC = 2;

    logic     clk;
    logic     rst;
    logic     instr_valid;
    instr_t   instr;
    addr_t    instr_addr;
    logic     instr_stall;
    logic     redirect_valid;
    addr_t    redirect_addr;
    logic     wb_valid;
    reg_sel_t wb_rd;
    xdata_t   wb_data;
    logic     exception;

    // program table, one row per instruction word
    addr_t    prog_addr [64];
    instr_t   prog_instr [64];
    logic     prog_wb [64];
    reg_sel_t prog_rd [64];
    xdata_t   prog_data [64];
    logic     prog_redir [64];
    addr_t    prog_target [64];
    logic     prog_exc [64];
    int       n_entries;

    int       exp_kind [$];
    reg_sel_t exp_rd [$];
    xdata_t   exp_val [$];

    int       errors;
    int       checks;
    int       pc_idx;
    int       end_idx;
    logic     fetch_on;
    logic     exc_seen;

    core_exec_top dut0 (.*);

    always #4 clk = !clk;

    function automatic instr_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP, 2'b11};
    endfunction

    function automatic instr_t enc_i(int imm, int rs1, int f3, int rd, opcode_t opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc, 2'b11};
    endfunction

    function automatic instr_t enc_u(int imm, int rd, opcode_t opc);
        return {imm[19:0], rd[4:0], opc, 2'b11};
    endfunction

    function automatic instr_t enc_j(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL, 2'b11};
    endfunction

    function automatic instr_t enc_b(int off, int rs2, int rs1, int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                OPC_BRANCH, 2'b11};
    endfunction

    function automatic int find_index(addr_t a);
        for (int i = 0; i < n_entries; i++)
            if (prog_addr[i] == a)
                return i;
        return -1;
    endfunction

    task automatic add_entry(int a, instr_t w, int wb, int rd, int data, int redir,
                             int target, int exc);
        prog_addr[n_entries] = addr_t'(a);
        prog_instr[n_entries] = w;
        prog_wb[n_entries] = wb != 0;
        prog_rd[n_entries] = rd[4:0];
        prog_data[n_entries] = xdata_t'(data);
        prog_redir[n_entries] = redir != 0;
        prog_target[n_entries] = addr_t'(target);
        prog_exc[n_entries] = exc != 0;
        n_entries++;
    endtask

    task automatic check_xdata(string name, xdata_t got, xdata_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg_sel(string name, reg_sel_t got, reg_sel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic drop_event();
        void'(exp_kind.pop_front());
        void'(exp_rd.pop_front());
        void'(exp_val.pop_front());
    endtask

    task automatic build_table();
        n_entries = 0;
        add_entry(0, enc_i(5, 0, 0, 1, OPC_OP_IMM), 1, 1, 5, 0, 0, 0);
        add_entry(4, enc_i(-3, 0, 0, 2, OPC_OP_IMM), 1, 2, 32'hFFFFFFFD, 0, 0, 0);
        add_entry(8, enc_r(0, 2, 1, 0, 3), 1, 3, 2, 0, 0, 0);
        add_entry(12, enc_r(32, 2, 1, 0, 4), 1, 4, 8, 0, 0, 0);
        add_entry(16, enc_r(0, 1, 2, 2, 5), 1, 5, 1, 0, 0, 0);
        add_entry(20, enc_r(0, 1, 2, 3, 6), 1, 6, 0, 0, 0, 0);
        add_entry(24, enc_r(0, 2, 1, 4, 7), 1, 7, 32'hFFFFFFF8, 0, 0, 0);
        add_entry(28, enc_r(0, 2, 1, 6, 8), 1, 8, 32'hFFFFFFFD, 0, 0, 0);
        add_entry(32, enc_r(0, 2, 1, 7, 9), 1, 9, 5, 0, 0, 0);
        add_entry(36, enc_r(0, 1, 1, 1, 10), 1, 10, 32'hA0, 0, 0, 0);
        add_entry(40, enc_r(0, 1, 2, 5, 11), 1, 11, 32'h07FFFFFF, 0, 0, 0);
        add_entry(44, enc_r(32, 1, 2, 5, 12), 1, 12, 32'hFFFFFFFF, 0, 0, 0);
        add_entry(48, enc_i(3, 1, 1, 13, OPC_OP_IMM), 1, 13, 32'h28, 0, 0, 0);
        add_entry(52, enc_i(32'h401, 2, 5, 14, OPC_OP_IMM), 1, 14, 32'hFFFFFFFE, 0, 0, 0);
        add_entry(56, enc_u(32'h12345, 15, OPC_LUI), 1, 15, 32'h12345000, 0, 0, 0);
        add_entry(60, enc_u(1, 16, OPC_AUIPC), 1, 16, 32'h103C, 0, 0, 0);
        // write to x0 is silent
        add_entry(64, enc_i(7, 1, 0, 0, OPC_OP_IMM), 0, 0, 0, 0, 0, 0);
        add_entry(68, enc_i(240, 2, 7, 17, OPC_OP_IMM), 1, 17, 32'hF0, 0, 0, 0);
        add_entry(72, enc_b(8, 2, 1, 0), 0, 0, 0, 0, 0, 0);
        add_entry(76, enc_b(12, 2, 1, 1), 0, 0, 0, 1, 88, 0);
        add_entry(80, enc_i(1, 0, 0, 18, OPC_OP_IMM), 1, 18, 1, 0, 0, 0);
        add_entry(84, enc_i(2, 0, 0, 18, OPC_OP_IMM), 1, 18, 2, 0, 0, 0);
        add_entry(88, enc_j(12, 19), 1, 19, 92, 1, 100, 0);
        add_entry(92, enc_i(1, 0, 0, 20, OPC_OP_IMM), 1, 20, 1, 0, 0, 0);
        add_entry(96, enc_i(2, 0, 0, 20, OPC_OP_IMM), 1, 20, 2, 0, 0, 0);
        add_entry(100, enc_i(120, 0, 0, 21, OPC_OP_IMM), 1, 21, 120, 0, 0, 0);
        add_entry(104, enc_i(4, 21, 0, 22, OPC_JALR), 1, 22, 108, 1, 124, 0);
        for (int k = 0; k < 4; k++)
            add_entry(108 + 4 * k, enc_i(k + 1, 0, 0, 23, OPC_OP_IMM), 1, 23, k + 1, 0, 0, 0);
        add_entry(124, enc_b(8, 1, 2, 4), 0, 0, 0, 1, 132, 0);
        add_entry(128, enc_i(9, 0, 0, 24, OPC_OP_IMM), 1, 24, 9, 0, 0, 0);
        add_entry(132, enc_b(8, 1, 2, 5), 0, 0, 0, 0, 0, 0);
        add_entry(136, enc_b(8, 1, 2, 6), 0, 0, 0, 0, 0, 0);
        add_entry(140, enc_b(8, 1, 2, 7), 0, 0, 0, 1, 148, 0);
        add_entry(144, enc_i(9, 0, 0, 24, OPC_OP_IMM), 1, 24, 9, 0, 0, 0);
        add_entry(148, enc_i(1, 4, 0, 25, OPC_OP_IMM), 1, 25, 9, 0, 0, 0);
        add_entry(152, enc_r(0, 25, 25, 0, 26), 1, 26, 18, 0, 0, 0);
        add_entry(156, enc_r(0, 25, 26, 0, 27), 1, 27, 27, 0, 0, 0);
        add_entry(160, 32'hFFFFFFFF, 0, 0, 0, 0, 0, 1);
        add_entry(164, enc_i(1, 0, 0, 28, OPC_OP_IMM), 1, 28, 1, 0, 0, 0);
        add_entry(168, enc_i(1, 0, 0, 29, OPC_OP_IMM), 1, 29, 1, 0, 0, 0);
        // second program ends on a misaligned jalr target
        add_entry(512, enc_i(518, 0, 0, 1, OPC_OP_IMM), 1, 1, 518, 0, 0, 0);
        add_entry(516, enc_i(0, 1, 0, 2, OPC_JALR), 0, 0, 0, 0, 0, 1);
        add_entry(520, enc_i(1, 0, 0, 3, OPC_OP_IMM), 1, 3, 1, 0, 0, 0);
        add_entry(524, enc_i(1, 0, 0, 4, OPC_OP_IMM), 1, 4, 1, 0, 0, 0);
    endtask

    // walk the table along the taken path to get the expected event order
    task automatic expect_path(int start, int last);
        int i;
        int steps;
        i = start;
        steps = 0;
        while (i >= 0 && i <= last && steps < 200) begin
            steps++;
            if (prog_exc[i]) begin
                exp_kind.push_back(EV_EXC);
                exp_rd.push_back('0);
                exp_val.push_back('0);
                break;
            end
            if (prog_wb[i]) begin
                exp_kind.push_back(EV_WB);
                exp_rd.push_back(prog_rd[i]);
                exp_val.push_back(prog_data[i]);
            end
            if (prog_redir[i]) begin
                exp_kind.push_back(EV_REDIR);
                exp_rd.push_back('0);
                exp_val.push_back(xdata_t'(prog_target[i]));
                i = find_index(prog_target[i]);
            end else begin
                i++;
            end
        end
    endtask

    // fetch model
    always @(posedge clk) begin
        if (rst || !fetch_on) begin
            instr_valid <= 1'b0;
        end else begin
            if (redirect_valid) begin
                pc_idx = find_index(redirect_addr);
                if (pc_idx < 0) begin
                    errors++;
                    $display("redirect to %h matches no table entry", redirect_addr);
                end
            end else if (instr_valid && !instr_stall) begin
                pc_idx++;
            end
            if (pc_idx < 0 || pc_idx > end_idx || $urandom % 4 == 0) begin
                instr_valid <= 1'b0;
            end else begin
                instr_valid <= 1'b1;
                instr <= prog_instr[pc_idx];
                instr_addr <= prog_addr[pc_idx];
            end
        end
    end

    // monitor
    always @(posedge clk) begin
        if (!rst) begin
            if (wb_valid) begin
                if (exp_kind.size() > 0 && exp_kind[0] == EV_WB) begin
                    check_reg_sel("wb_rd", wb_rd, exp_rd[0]);
                    check_xdata("wb_data", wb_data, exp_val[0]);
                    drop_event();
                end else begin
                    errors++;
                    $display("unexpected writeback of %h to x%0d", wb_data, wb_rd);
                end
            end
            if (redirect_valid) begin
                if (exp_kind.size() > 0 && exp_kind[0] == EV_REDIR) begin
                    check_addr("redirect_addr", redirect_addr, addr_t'(exp_val[0]));
                    drop_event();
                end else begin
                    errors++;
                    $display("unexpected redirect to %h", redirect_addr);
                end
            end
            if (exception && !exc_seen) begin
                exc_seen = 1'b1;
                if (exp_kind.size() > 0 && exp_kind[0] == EV_EXC) begin
                    drop_event();
                end else begin
                    errors++;
                    $display("exception raised where none was expected");
                end
            end
            if (exc_seen)
                check_bit("exception", exception, 1'b1);
        end
    end

    task automatic run_program(int start, int last);
        int cycles;
        fetch_on = 1'b0;
        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        exp_kind.delete();
        exp_rd.delete();
        exp_val.delete();
        exc_seen = 1'b0;
        pc_idx = start;
        end_idx = last;
        expect_path(start, last);
        fetch_on = 1'b1;
        repeat (7) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_bit("instr_stall", instr_stall, 1'b0);
        check_bit("redirect_valid", redirect_valid, 1'b0);
        check_bit("wb_valid", wb_valid, 1'b0);
        check_bit("exception", exception, 1'b0);
        cycles = 0;
        while (exp_kind.size() > 0 && cycles < 3000) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_kind.size() > 0) begin
            errors++;
            $display("timed out with %0d expected events still pending", exp_kind.size());
        end
        cycles = 0;
        while (!instr_stall && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (!instr_stall) begin
            errors++;
            $display("timed out waiting for instr_stall after the exception");
        end
        repeat (20) begin
            @(posedge clk);
            check_bit("instr_stall", instr_stall, 1'b1);
            check_bit("wb_valid", wb_valid, 1'b0);
        end
        fetch_on = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        instr_addr = '0;
        errors = 0;
        checks = 0;
        fetch_on = 1'b0;
        exc_seen = 1'b0;
        pc_idx = 0;
        end_idx = 0;
        void'($urandom(72962));
        build_table();
        run_program(0, 42);
        run_program(43, 46);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== flist.f ====
rv_pkg.sv
decode.sv
exec_int.sv
exec_branch.sv
exec.sv
writeback.sv
core_exec_top.sv
tb_core_exec.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -f flist.f --top-module tb_core_exec --Mdir obj_dir -o sim
./obj_dir/sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0
